// File: sim.f
src/z80_idx_pkg.sv
src/idx_step_counter.sv
src/idx_itable_reg.sv
src/idx_ld_decoder.sv
src/idx_operand_regs.sv
src/idx_store_unit.sv
testbench/idx_store_unit_chk.sv
testbench/tb_idx_store_unit.sv

// File: Makefile
# Verilator build and run of the indexed store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_idx_store_unit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_idx_store_unit.sv
/* random DD/FD 36 d n stream against a reference model, inputs change on the falling edge
   ix and iy are held from start until the write, since the unit samples them late */
`timescale 1ns/100ps

module tb_idx_store_unit;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int NUM_INSTR      = 150;
    localparam int MAX_GAP        = 5;

    logic               clk;
    logic               rst_n;
    logic               start;
    z80_idx_pkg::byte_t prefix;
    z80_idx_pkg::byte_t opcode;
    logic               byte_valid;
    z80_idx_pkg::byte_t byte_data;
    z80_idx_pkg::addr_t ix;
    z80_idx_pkg::addr_t iy;
    logic               busy;
    logic               byte_req;
    logic               mem_wr;
    z80_idx_pkg::addr_t mem_addr;
    z80_idx_pkg::byte_t mem_data;
    logic               illegal;

    idx_store_unit i_idx_store_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .prefix     (prefix),
        .opcode     (opcode),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .ix         (ix),
        .iy         (iy),
        .busy       (busy),
        .byte_req   (byte_req),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input z80_idx_pkg::addr_t got,
                              input z80_idx_pkg::addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input z80_idx_pkg::byte_t got,
                              input z80_idx_pkg::byte_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    // offers one operand byte after a random stall, with stray starts while busy
    task automatic send_byte(input z80_idx_pkg::byte_t value);
        int cnt;
        int gap;
        cnt = 0;
        while (!byte_req) begin
            if (cnt == TIMEOUT_CYCLES) begin
                stop_with_failure("timed out waiting for byte_req");
            end
            @(negedge clk);
            cnt++;
        end
        gap = $urandom_range(0, MAX_GAP);
        repeat (gap) begin
            byte_valid = 1'b0;
            byte_data  = z80_idx_pkg::byte_t'($urandom);
            start      = ($urandom_range(0, 1) == 1); // must be ignored, unit is busy
            prefix     = ($urandom_range(0, 1) == 1) ? z80_idx_pkg::FD_PREFIX
                                                     : z80_idx_pkg::DD_PREFIX;
            opcode     = z80_idx_pkg::byte_t'($urandom);
            @(negedge clk);
            check_flag("byte_req", byte_req, 1'b1);
            check_flag("busy", busy, 1'b1);
        end
        start      = 1'b0;
        byte_valid = 1'b1;
        byte_data  = value;
        @(negedge clk);
        byte_valid = 1'b0;
    endtask

    task automatic run_instr(input z80_idx_pkg::byte_t pfx, input z80_idx_pkg::byte_t opc,
                             input z80_idx_pkg::byte_t d, input z80_idx_pkg::byte_t n,
                             input z80_idx_pkg::addr_t ix_v, input z80_idx_pkg::addr_t iy_v);
        z80_idx_pkg::addr_t base;
        z80_idx_pkg::addr_t exp_addr;
        int                 dv;
        int                 sum;
        int                 gap;
        int                 cnt;
        // reference: index + signed d, kept to 16 bits
        base     = (pfx == z80_idx_pkg::FD_PREFIX) ? iy_v : ix_v;
        dv       = int'($signed(d));
        sum      = int'(base) + dv;
        exp_addr = z80_idx_pkg::addr_t'(sum & 32'hffff);

        // idle cycles, bytes offered here must be ignored
        gap = $urandom_range(0, MAX_GAP);
        repeat (gap) begin
            byte_valid = 1'b1;
            byte_data  = z80_idx_pkg::byte_t'($urandom);
            @(negedge clk);
            check_flag("byte_req", byte_req, 1'b0);
        end
        check_flag("busy", busy, 1'b0);
        start      = 1'b1;
        prefix     = pfx;
        opcode     = opc;
        ix         = ix_v;
        iy         = iy_v;
        byte_valid = 1'b0;
        @(negedge clk);
        start = 1'b0;
        check_flag("busy", busy, 1'b1);

        if (opc != z80_idx_pkg::LD_IMM_OPCODE) begin
            check_flag("illegal", illegal, 1'b1);
            check_flag("byte_req", byte_req, 1'b0);
            @(negedge clk);
            check_flag("illegal", illegal, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_flag("mem_wr", mem_wr, 1'b0);
        end else begin
            check_flag("illegal", illegal, 1'b0);
            send_byte(d);
            send_byte(n);
            // now just past the edge that took n
            cnt = 0;
            while (!mem_wr) begin
                if (cnt == TIMEOUT_CYCLES) begin
                    stop_with_failure("timed out waiting for mem_wr");
                end
                check_flag("byte_req", byte_req, 1'b0);
                check_flag("busy", busy, 1'b1);
                byte_valid = 1'b1;
                byte_data  = z80_idx_pkg::byte_t'($urandom);
                @(negedge clk);
                cnt++;
            end
            if (cnt + 1 != 2 + 1) begin
                stop_with_failure($sformatf("mem_wr rose %0d edges after n, expected 2", cnt));
            end
            check_addr("mem_addr", mem_addr, exp_addr);
            check_byte("mem_data", mem_data, n);
            check_flag("busy", busy, 1'b0);
            check_flag("illegal", illegal, 1'b0);
            byte_valid = 1'b0;
            @(negedge clk);
            check_flag("mem_wr", mem_wr, 1'b0);
        end
    endtask

    initial begin
        z80_idx_pkg::byte_t pfx;
        z80_idx_pkg::byte_t opc;
        void'($urandom(32'hcd42));
        rst_n      = 1'b0;
        start      = 1'b0;
        prefix     = '0;
        opcode     = '0;
        byte_valid = 1'b0;
        byte_data  = '0;
        ix         = '0;
        iy         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("busy", busy, 1'b0);
        check_flag("byte_req", byte_req, 1'b0);
        check_flag("mem_wr", mem_wr, 1'b0);
        check_flag("illegal", illegal, 1'b0);

        // wrap upward through ffff, then a negative d below zero on iy
        run_instr(z80_idx_pkg::DD_PREFIX, 8'h36, 8'h20, 8'ha5, 16'hfff0, 16'h1234);
        run_instr(z80_idx_pkg::FD_PREFIX, 8'h36, 8'h80, 8'h5a, 16'h1234, 16'h0010);
        // reject, then a normal store right behind it
        run_instr(z80_idx_pkg::DD_PREFIX, 8'h46, 8'h01, 8'h02, 16'h4000, 16'h8000);
        run_instr(z80_idx_pkg::DD_PREFIX, 8'h36, 8'hff, 8'h3c, 16'h4000, 16'h8000);

        for (int i = 0; i < NUM_INSTR; i++) begin
            pfx = ($urandom_range(0, 1) == 1) ? z80_idx_pkg::FD_PREFIX : z80_idx_pkg::DD_PREFIX;
            if ($urandom_range(0, 3) != 0) begin
                opc = z80_idx_pkg::LD_IMM_OPCODE;
            end else begin
                do begin
                    opc = z80_idx_pkg::byte_t'($urandom);
                end while (opc == z80_idx_pkg::LD_IMM_OPCODE);
            end
            run_instr(pfx, opc, z80_idx_pkg::byte_t'($urandom), z80_idx_pkg::byte_t'($urandom),
                      z80_idx_pkg::addr_t'($urandom), z80_idx_pkg::addr_t'($urandom));
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: testbench/idx_store_unit_chk.sv
/* protocol properties on the top level ports, bound into idx_store_unit
   sampled on the rising edge, all but the reset check are off while rst_n is low */
`timescale 1ns/100ps

module idx_store_unit_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic byte_req,
    input logic mem_wr,
    input logic illegal
);

    // the write is a single-cycle pulse
    a_wr_single : assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr |=> !mem_wr)
        else $error("mem_wr high on two consecutive cycles");

    a_wr_not_illegal : assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_wr && illegal))
        else $error("mem_wr and illegal high together");

    a_req_busy : assert property (@(posedge clk) disable iff (!rst_n)
        byte_req |-> busy) // bytes are only asked for mid-instruction
        else $error("byte_req high while not busy");

    a_reset_quiet : assert property (@(posedge clk)
        !rst_n |=> (!busy && !mem_wr && !illegal))
        else $error("outputs not idle in the cycle after reset");

endmodule

bind idx_store_unit idx_store_unit_chk i_idx_store_unit_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (busy),
    .byte_req (byte_req),
    .mem_wr   (mem_wr),
    .illegal  (illegal)
);

// File: src/idx_store_unit.sv
/* LD (IX+d),n and LD (IY+d),n sequencer, bytes are taken only while byte_req is high
   no wait states on the write, illegal is a one-cycle pulse right after start */
`timescale 1ns/100ps

module idx_store_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  z80_idx_pkg::byte_t prefix,
    input  z80_idx_pkg::byte_t opcode,
    input  logic               byte_valid,
    input  z80_idx_pkg::byte_t byte_data,
    input  z80_idx_pkg::addr_t ix,
    input  z80_idx_pkg::addr_t iy,
    output logic               busy,
    output logic               byte_req,
    output logic               mem_wr,
    output z80_idx_pkg::addr_t mem_addr,
    output z80_idx_pkg::byte_t mem_data,
    output logic               illegal
);

    z80_idx_pkg::step_t step;

    logic use_iy;
    logic ld_imm_class;

    logic capture_disp;
    logic capture_imm;
    logic advance;
    logic calc_addr;
    logic write_now;
    logic clear_step;
    logic clear_itable;

    idx_step_counter i_idx_step_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .advance    (advance),
        .clear_step (clear_step),
        .step       (step),
        .busy       (busy)
    );

    idx_itable_reg i_idx_itable_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .busy         (busy),
        .prefix       (prefix),
        .opcode       (opcode),
        .clear_itable (clear_itable),
        .use_iy       (use_iy),
        .ld_imm_class (ld_imm_class)
    );

    idx_ld_decoder i_idx_ld_decoder (
        .step         (step),
        .ld_imm_class (ld_imm_class),
        .byte_valid   (byte_valid),
        .byte_req     (byte_req),
        .capture_disp (capture_disp),
        .capture_imm  (capture_imm),
        .advance      (advance),
        .calc_addr    (calc_addr),
        .write_now    (write_now),
        .clear_step   (clear_step),
        .clear_itable (clear_itable),
        .illegal      (illegal)
    );

    idx_operand_regs i_idx_operand_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_data    (byte_data),
        .capture_disp (capture_disp),
        .capture_imm  (capture_imm),
        .calc_addr    (calc_addr),
        .write_now    (write_now),
        .use_iy       (use_iy),
        .ix           (ix),
        .iy           (iy),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data)
    );

endmodule

// File: src/idx_operand_regs.sv
/* ix and iy are sampled on the calc_addr cycle only, later changes do not move the write
   mem_addr and mem_data are only meaningful while mem_wr is high */
`timescale 1ns/100ps

module idx_operand_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  z80_idx_pkg::byte_t byte_data,
    input  logic               capture_disp,
    input  logic               capture_imm,
    input  logic               calc_addr,
    input  logic               write_now,
    input  logic               use_iy,
    input  z80_idx_pkg::addr_t ix,
    input  z80_idx_pkg::addr_t iy,
    output logic               mem_wr,
    output z80_idx_pkg::addr_t mem_addr,
    output z80_idx_pkg::byte_t mem_data
);

    z80_idx_pkg::byte_t dt_q; // displacement
    z80_idx_pkg::byte_t op_q; // immediate
    z80_idx_pkg::addr_t ea_q;

    z80_idx_pkg::addr_t index_sel;
    z80_idx_pkg::addr_t disp_ext;
    z80_idx_pkg::addr_t ea_sum;

    logic               wr_q;
    z80_idx_pkg::addr_t addr_q;
    z80_idx_pkg::byte_t data_q;

    // operand bytes
    always_ff @(posedge clk) begin
        if (capture_disp) begin
            dt_q <= byte_data;
        end
        if (capture_imm) begin
            op_q <= byte_data;
        end
    end

    assign index_sel = use_iy ? iy : ix;
    assign disp_ext  = {{8{dt_q[7]}}, dt_q}; // sign extend d
    assign ea_sum    = index_sel + disp_ext; // carry out dropped, wraps at 64k

    always_ff @(posedge clk) begin
        if (calc_addr) begin
            ea_q <= ea_sum;
        end
    end

    // write port, pulse is one cycle since write_now is
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= write_now;
        end
    end

    always_ff @(posedge clk) begin
        if (write_now) begin
            addr_q <= ea_q;
            data_q <= op_q;
        end
    end

    assign mem_wr   = wr_q;
    assign mem_addr = addr_q;
    assign mem_data = data_q;

endmodule

// File: src/idx_ld_decoder.sv
/* purely combinational, outputs follow step and byte_valid in the same cycle
   each step line enables exactly one group of control pulses */
`timescale 1ns/100ps

module idx_ld_decoder (
    input  z80_idx_pkg::step_t step,
    input  logic               ld_imm_class,
    input  logic               byte_valid,
    output logic               byte_req,
    output logic               capture_disp,
    output logic               capture_imm,
    output logic               advance,
    output logic               calc_addr,
    output logic               write_now,
    output logic               clear_step,
    output logic               clear_itable,
    output logic               illegal
);

    // one-hot step lines
    logic t_disp;
    logic t_imm;
    logic t_addr;
    logic t_write;

    // step_disp split by instruction class
    logic disp_ok;
    logic disp_bad;

    logic take_byte;
    logic finish;

    always_comb begin
        t_disp  = 1'b0;
        t_imm   = 1'b0;
        t_addr  = 1'b0;
        t_write = 1'b0;
        case (step)
            z80_idx_pkg::step_disp:  t_disp  = 1'b1;
            z80_idx_pkg::step_imm:   t_imm   = 1'b1;
            z80_idx_pkg::step_addr:  t_addr  = 1'b1;
            z80_idx_pkg::step_write: t_write = 1'b1;
            default: ; // idle drives nothing
        endcase
    end

    assign disp_ok  = t_disp & ld_imm_class;
    assign disp_bad = t_disp & ~ld_imm_class;

    // d and n both come in over the byte strobe
    assign byte_req  = disp_ok | t_imm;
    assign take_byte = byte_req & byte_valid;

    // disp: latch Dt
    assign capture_disp = disp_ok & byte_valid;

    // imm: latch OP
    assign capture_imm = t_imm & byte_valid;

    // addr: index + d
    assign calc_addr = t_addr;

    // write and end of sequence
    assign write_now = t_write;

    assign advance = take_byte | t_addr;

    // both the normal end and a rejected opcode return to idle
    assign finish       = t_write | disp_bad;
    assign clear_step   = finish;
    assign clear_itable = finish;

    assign illegal = disp_bad; // one cycle, step leaves disp at the next edge

endmodule

// File: src/idx_itable_reg.sv
/* latches prefix kind and opcode class at start while not busy
   a prefix other than DD or FD is treated as an unsupported class */
`timescale 1ns/100ps

module idx_itable_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                busy,
    input  z80_idx_pkg::byte_t  prefix,
    input  z80_idx_pkg::byte_t  opcode,
    input  logic                clear_itable,
    output logic                use_iy,
    output logic                ld_imm_class
);

    logic load;
    logic is_fd;
    logic is_index_prefix;
    logic use_iy_q;
    logic ld_imm_q;

    assign load            = start & ~busy; // a start during a running instruction is dropped
    assign is_fd           = (prefix == z80_idx_pkg::FD_PREFIX);
    assign is_index_prefix = is_fd | (prefix == z80_idx_pkg::DD_PREFIX);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            use_iy_q <= 1'b0;
            ld_imm_q <= 1'b0;
        end else if (clear_itable) begin
            use_iy_q <= 1'b0;
            ld_imm_q <= 1'b0;
        end else if (load) begin
            use_iy_q <= is_fd;
            ld_imm_q <= is_index_prefix & (opcode == z80_idx_pkg::LD_IMM_OPCODE);
        end
    end

    assign use_iy       = use_iy_q;
    assign ld_imm_class = ld_imm_q;

endmodule

// File: src/idx_step_counter.sv
/* step register of the sequence, start is only honoured while idle
   clear_step wins over advance when both are raised */
`timescale 1ns/100ps

module idx_step_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               advance,
    input  logic               clear_step,
    output z80_idx_pkg::step_t step,
    output logic               busy
);

    z80_idx_pkg::step_t step_q;
    z80_idx_pkg::step_t step_next;

    // next step in the fixed order of the instruction
    always_comb begin
        step_next = step_q;
        if (clear_step) begin
            step_next = z80_idx_pkg::step_idle;
        end else if (step_q == z80_idx_pkg::step_idle) begin
            if (start) begin
                step_next = z80_idx_pkg::step_disp;
            end
        end else if (advance) begin
            case (step_q)
                z80_idx_pkg::step_disp:  step_next = z80_idx_pkg::step_imm;
                z80_idx_pkg::step_imm:   step_next = z80_idx_pkg::step_addr;
                z80_idx_pkg::step_addr:  step_next = z80_idx_pkg::step_write;
                default:                 step_next = z80_idx_pkg::step_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q <= z80_idx_pkg::step_idle;
        end else begin
            step_q <= step_next;
        end
    end

    assign step = step_q;
    assign busy = (step_q != z80_idx_pkg::step_idle);

endmodule

// File: src/z80_idx_pkg.sv
/* shared widths, step encoding and opcode constants for the indexed store unit
   only DD/FD 36 d n is recognised, every other opcode is left to the caller */
package z80_idx_pkg;

    localparam int BYTE_W = 8;
    localparam int ADDR_W = 16;
    localparam int STEP_W = 3;

    // data byte as seen on the byte strobe and the write port
    typedef logic [BYTE_W-1:0] byte_t;

    // 16-bit address space, sums wrap modulo 65536
    typedef logic [ADDR_W-1:0] addr_t;

    // one step per cycle of the sequence, idle means no instruction is running
    typedef enum logic [STEP_W-1:0] {
        step_idle  = 3'd0,
        step_disp  = 3'd1, // waiting for d
        step_imm   = 3'd2, // waiting for n
        step_addr  = 3'd3,
        step_write = 3'd4
    } step_t;

    // index prefixes
    localparam byte_t DD_PREFIX = 8'hdd; // IX
    localparam byte_t FD_PREFIX = 8'hfd; // IY

    // LD (IX+d),n / LD (IY+d),n
    localparam byte_t LD_IMM_OPCODE = 8'h36;

endpackage
